// ==== sources.f ====
src/cmp_pkg.sv
src/cmp_dispatch_capture.sv
src/cmp_station.sv
src/cmp_unit.sv
src/cmp_result_queue.sv
src/cmp_cluster_top.sv
test/cmp_cluster_assert.sv
test/cmp_cluster_tb.sv

// ==== test/cmp_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_cluster_tb;
    import cmp_pkg::*;

    localparam int NUM_DISPATCH   = 32;
    localparam int TIMEOUT_CYCLES = 40 * NUM_DISPATCH + 200;
    localparam int NUM_TAGS       = 1 << TAG_W;

    logic      clk;
    logic      rst_n_i;
    logic      flush_i;
    dispatch_t dispatch_i;
    cdb_t      snoop_i;
    logic      credit_o;
    logic      cdb_credit_i = 1'b0;
    cdb_t      result_o;

    // dispatcher and bus side models
    int disp_credits;
    int credit_pulses;
    int results_seen;
    int cycle_count;
    int due_q[$];
    bit hold_credits;

    // scoreboard indexed by dest tag
    bit               pending    [NUM_TAGS];
    logic [XLEN-1:0]  exp_val    [NUM_TAGS];
    bit               need_a     [NUM_TAGS];
    bit               need_b     [NUM_TAGS];
    logic [TAG_W-1:0] need_a_tag [NUM_TAGS];
    logic [TAG_W-1:0] need_b_tag [NUM_TAGS];
    int               pending_count;
    logic [TAG_W-1:0] order_q[$];
    logic [TAG_W-1:0] exp_order [4];

    int               errors;
    int               checks;
    int               tests_done;
    int               err_base;
    int               snap;
    int               next_dest;
    logic [TAG_W-1:0] got_tag;
    logic [XLEN-1:0]  a_val;
    logic [XLEN-1:0]  b_val;
    logic [XLEN-1:0]  v8;
    logic [XLEN-1:0]  v9;
    logic [XLEN-1:0]  v10;

    cmp_cluster_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .dispatch_i   (dispatch_i),
        .snoop_i      (snoop_i),
        .credit_o     (credit_o),
        .cdb_credit_i (cdb_credit_i),
        .result_o     (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // slt rules, signed order by flipping the sign bit
    function automatic logic [XLEN-1:0] expected_compare(input cmp_op_e op_in,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        logic lt_u;
        logic lt_s;
        logic hit;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op_in)
            CMP_EQ:  hit = (a == b);
            CMP_NE:  hit = (a != b);
            CMP_LT:  hit = lt_s;
            CMP_GE:  hit = !lt_s;
            CMP_LTU: hit = lt_u;
            default: hit = !lt_u;
        endcase
        return {{(XLEN - 1){1'b0}}, hit};
    endfunction

    function automatic logic [XLEN-1:0] edge_value(input int unsigned sel);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic int total_errors();
        return errors + dut0.u_assert.fail_count;
    endfunction

    // cycle count, dispatcher credits, bus credit schedule, timeout
    always @(posedge clk) begin
        cycle_count++;
        if (!rst_n_i) begin
            disp_credits = STATION_DEPTH;
        end else begin
            if (flush_i) begin
                disp_credits = STATION_DEPTH;
            end else begin
                disp_credits = disp_credits + int'(credit_o) - int'(dispatch_i.valid);
            end
            if (credit_o) begin
                credit_pulses++;
            end
            if (result_o.valid) begin
                due_q.push_back(cycle_count + 1 + $urandom_range(0, 4));
            end
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d results missing",
                     cycle_count, pending_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // bus returns one credit per cycle once it is due
    always @(negedge clk) begin
        cdb_credit_i = 1'b0;
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle_count) begin
            void'(due_q.pop_front());
            cdb_credit_i = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && result_o.valid) begin
            got_tag = result_o.tag;
            checks++;
            results_seen++;
            order_q.push_back(got_tag);
            assert (pending[got_tag]) else begin
                errors++;
                $display("unexpected result for tag %0d at %0t", got_tag, $time);
            end
            if (pending[got_tag]) begin
                assert (!need_a[got_tag] && !need_b[got_tag]) else begin
                    errors++;
                    $display("result for tag %0d at %0t came before its operand broadcast",
                             got_tag, $time);
                end
                assert (result_o.value == exp_val[got_tag]) else begin
                    errors++;
                    $display("ERR t=%0t result_o.value tag %0d got %h expected %h",
                             $time, got_tag, result_o.value, exp_val[got_tag]);
                end
                pending[got_tag] = 1'b0;
                pending_count--;
            end
        end
    end

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic clear_waits(input logic [TAG_W-1:0] tag);
        for (int d = 0; d < NUM_TAGS; d++) begin
            if (need_a[d] && need_a_tag[d] == tag) begin
                need_a[d] = 1'b0;
            end
            if (need_b[d] && need_b_tag[d] == tag) begin
                need_b[d] = 1'b0;
            end
        end
    endtask

    // waiting operands carry junk values; bypass snoops tag_a in the dispatch cycle
    task automatic send_cmp(input cmp_op_e op_in, input logic [TAG_W-1:0] dest,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input bit wait_a, input logic [TAG_W-1:0] tag_a,
                            input bit wait_b, input logic [TAG_W-1:0] tag_b,
                            input bit bypass);
        operand_t s1;
        operand_t s2;
        while (disp_credits == 0 || pending[dest]) begin
            @(negedge clk);
        end
        s1.ready = !wait_a;
        s1.tag   = tag_a;
        s1.value = wait_a ? $urandom : a;
        s2.ready = !wait_b;
        s2.tag   = tag_b;
        s2.value = wait_b ? $urandom : b;
        exp_val[dest]    = expected_compare(op_in, a, b);
        need_a[dest]     = wait_a;
        need_a_tag[dest] = tag_a;
        need_b[dest]     = wait_b;
        need_b_tag[dest] = tag_b;
        pending[dest]    = 1'b1;
        pending_count++;
        dispatch_i = '{valid: 1'b1, op: op_in, src1: s1, src2: s2, dest_tag: dest};
        if (bypass) begin
            snoop_i = '{valid: 1'b1, tag: tag_a, value: a};
            clear_waits(tag_a);
        end
        @(negedge clk);
        dispatch_i.valid = 1'b0;
        snoop_i.valid    = 1'b0;
    endtask

    task automatic send_ready(input cmp_op_e op_in, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
        send_cmp(op_in, TAG_W'(next_dest), a, b, 1'b0, '0, 1'b0, '0, 1'b0);
        next_dest = (next_dest + 1) % 8;
    endtask

    task automatic snoop(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] value);
        snoop_i = '{valid: 1'b1, tag: tag, value: value};
        clear_waits(tag);
        @(negedge clk);
        snoop_i.valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending_count != 0 || due_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("test %0d %s: %0d errors", tests_done, name, total_errors() - err_base);
        err_base = total_errors();
    endtask

    initial begin
        void'($urandom(32'h0496_b847));
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        dispatch_i   = '0;
        snoop_i      = '0;
        hold_credits = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        // boundary pair and random pair per opcode
        for (int k = 0; k < 6; k++) begin
            send_ready(cmp_op_e'(k), edge_value($urandom_range(0, 4)),
                       edge_value($urandom_range(0, 4)));
            a_val = $urandom;
            b_val = ($urandom_range(0, 3) == 0) ? a_val : $urandom;
            send_ready(cmp_op_e'(k), a_val, b_val);
        end
        wait_idle();
        end_test("opcodes with ready operands");

        v8  = $urandom;
        v9  = $urandom;
        v10 = $urandom;
        send_cmp(CMP_GE, 4'd0, v8, 32'h0000_1234, 1'b1, 4'd8, 1'b0, '0, 1'b0);
        send_cmp(CMP_LTU, 4'd1, v9, v10, 1'b1, 4'd9, 1'b1, 4'd10, 1'b0);
        repeat (15) @(negedge clk);
        check_count("pending results before broadcast", pending_count, 2);
        snoop(4'd8, v8);
        snoop(4'd9, v9);
        repeat (5) @(negedge clk);
        snoop(4'd10, v10);
        wait_idle();
        end_test("operands woken by snoop");

        // second case snoops while the dispatch sits in the capture register
        v8 = $urandom;
        v9 = $urandom;
        send_cmp(CMP_NE, 4'd2, v8, v8, 1'b1, 4'd12, 1'b0, '0, 1'b1);
        send_cmp(CMP_LT, 4'd3, $urandom, v9, 1'b0, '0, 1'b1, 4'd13, 1'b0);
        snoop(4'd13, v9);
        wait_idle();
        end_test("same cycle snoop bypass");

        order_q.delete();
        snap = credit_pulses;
        v8   = $urandom;
        v9   = $urandom;
        v10  = $urandom;
        send_cmp(CMP_LT, 4'd0, v8, $urandom, 1'b1, 4'd8, 1'b0, '0, 1'b0);
        send_cmp(CMP_GEU, 4'd1, v9, $urandom, 1'b1, 4'd9, 1'b0, '0, 1'b0);
        send_cmp(CMP_EQ, 4'd2, v10, v10, 1'b1, 4'd10, 1'b0, '0, 1'b0);
        send_cmp(CMP_LTU, 4'd3, $urandom, v8, 1'b0, '0, 1'b1, 4'd8, 1'b0);
        @(negedge clk);
        check_count("disp_credits", disp_credits, 0);
        snoop(4'd10, v10);
        repeat (6) @(negedge clk);
        snoop(4'd8, v8);
        repeat (6) @(negedge clk);
        snoop(4'd9, v9);
        wait_idle();
        check_count("credit_o pulses", credit_pulses - snap, 4);
        check_count("result count", order_q.size(), 4);
        exp_order = '{4'd2, 4'd0, 4'd3, 4'd1};
        for (int i = 0; i < 4 && i < order_q.size(); i++) begin
            check_count("result_o.tag order", order_q[i], exp_order[i]);
        end
        end_test("full station and issue order");

        hold_credits = 1'b1;
        snap = results_seen;
        for (int k = 0; k < 4; k++) begin
            send_ready(cmp_op_e'($urandom_range(0, 5)), $urandom, $urandom);
        end
        repeat (30) @(negedge clk);
        assert (results_seen - snap <= CDB_CREDITS) else begin
            errors++;
            $display("more results than bus credits while credits were held back");
        end
        hold_credits = 1'b0;
        wait_idle();
        check_count("results after credit release", results_seen - snap, 4);
        end_test("bus credit back-pressure");

        // these four wait on a tag that only shows up after the flush
        for (int k = 0; k < 4; k++) begin
            send_cmp(CMP_EQ, TAG_W'(k), $urandom, $urandom, 1'b1, 4'd15, 1'b0, '0, 1'b0);
        end
        repeat (3) @(negedge clk);
        check_count("disp_credits", disp_credits, 0);
        snap    = credit_pulses;
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        for (int k = 0; k < 4; k++) begin
            pending[k] = 1'b0;
            pending_count--;
        end
        repeat (10) @(negedge clk);
        snoop(4'd15, $urandom);
        repeat (10) @(negedge clk);
        check_count("credit_o pulses after flush", credit_pulses - snap, 0);
        check_count("disp_credits", disp_credits, STATION_DEPTH);
        for (int k = 4; k < 8; k++) begin
            send_cmp(cmp_op_e'($urandom_range(0, 5)), TAG_W'(k), edge_value(k - 4),
                     $urandom, 1'b0, '0, 1'b0, '0, 1'b0);
        end
        wait_idle();
        end_test("flush and refill");

        $display("summary: %0d tests, %0d result checks, %0d errors",
                 tests_done, checks, total_errors());
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/cmp_cluster_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_cluster_assert (
    input logic               clk,
    input logic               rst_n_i,
    input logic               flush_i,
    input cmp_pkg::dispatch_t dispatch_i,
    input logic               credit_o,
    input logic               cdb_credit_i,
    input cmp_pkg::cdb_t      result_o
);
    import cmp_pkg::*;

    int disp_credits;
    int bus_credits;
    int fail_count = 0;

    // credit counts as the dispatcher and the bus see them
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_credits <= STATION_DEPTH;
            bus_credits  <= CDB_CREDITS;
        end else begin
            if (flush_i) begin
                disp_credits <= STATION_DEPTH;
            end else begin
                disp_credits <= disp_credits + int'(credit_o) - int'(dispatch_i.valid);
            end
            bus_credits <= bus_credits + int'(cdb_credit_i) - int'(result_o.valid);
        end
    end

    dispatch_credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
        disp_credits <= STATION_DEPTH)
        else begin
            fail_count++;
            $error("dispatch credits above station depth");
        end

    bus_credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_credits <= CDB_CREDITS)
        else begin
            fail_count++;
            $error("bus credits above their initial count");
        end

    result_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        result_o.valid |-> bus_credits > 0)
        else begin
            fail_count++;
            $error("result sent with no bus credit left");
        end

    dispatch_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        dispatch_i.valid |-> disp_credits > 0)
        else begin
            fail_count++;
            $error("dispatch arrived with no dispatch credit");
        end

    // outputs quiet right out of reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !credit_o && !result_o.valid)
        else begin
            fail_count++;
            $error("credit or result active just after reset");
        end

endmodule

bind cmp_cluster_top cmp_cluster_assert u_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .dispatch_i   (dispatch_i),
    .credit_o     (credit_o),
    .cdb_credit_i (cdb_credit_i),
    .result_o     (result_o)
);

`default_nettype wire

// ==== src/cmp_cluster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_cluster_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  cmp_pkg::dispatch_t dispatch_i,
    input  cmp_pkg::cdb_t      snoop_i,
    output logic               credit_o,
    input  logic               cdb_credit_i,
    output cmp_pkg::cdb_t      result_o
);
    import cmp_pkg::*;

    dispatch_t cap;
    issue_t    issue;
    cdb_t      res;
    logic      space;

    // registers dispatch and catches same-cycle broadcast
    cmp_dispatch_capture u_capture (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_i),
        .snoop_i    (snoop_i),
        .cap_o      (cap)
    );

    cmp_station u_station (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .cap_i    (cap),
        .snoop_i  (snoop_i),
        .space_i  (space),
        .issue_o  (issue),
        .credit_o (credit_o)
    );

    // flush does not reach the unit or the queue
    cmp_unit u_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (issue),
        .res_o   (res)
    );

    cmp_result_queue u_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .res_i        (res),
        .cdb_credit_i (cdb_credit_i),
        .result_o     (result_o),
        .space_o      (space)
    );

endmodule

`default_nettype wire

// ==== src/cmp_result_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_result_queue (
    input  logic          clk,
    input  logic          rst_n_i,
    input  cmp_pkg::cdb_t res_i,
    input  logic          cdb_credit_i,
    output cmp_pkg::cdb_t result_o,
    output logic          space_o
);
    import cmp_pkg::*;

    logic [TAG_W-1:0]        tag_mem [RESULT_DEPTH];
    logic [XLEN-1:0]         val_mem [RESULT_DEPTH];
    logic [RESULT_PTR_W-1:0] wr_ptr_q;
    logic [RESULT_PTR_W-1:0] rd_ptr_q;
    logic [RESULT_CNT_W-1:0] count_q;
    logic [CREDIT_W-1:0]     credits_q;
    logic [RESULT_CNT_W-1:0] occupied;
    logic                    send;
    logic                    out_valid_q;
    logic [TAG_W-1:0]        out_tag_q;
    logic [XLEN-1:0]         out_value_q;

    assign send = (count_q != '0) && (credits_q != '0);

    // result sitting in the unit already owns a slot
    assign occupied = count_q + RESULT_CNT_W'(res_i.valid);
    assign space_o  = occupied < RESULT_CNT_W'(RESULT_DEPTH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credits_q   <= CREDIT_W'(CDB_CREDITS);
            out_valid_q <= 1'b0;
        end else begin
            if (res_i.valid) begin
                wr_ptr_q <= (wr_ptr_q == RESULT_PTR_W'(RESULT_DEPTH - 1)) ?
                            '0 : wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= (rd_ptr_q == RESULT_PTR_W'(RESULT_DEPTH - 1)) ?
                            '0 : rd_ptr_q + 1'b1;
            end
            count_q     <= count_q + RESULT_CNT_W'(res_i.valid) - RESULT_CNT_W'(send);
            credits_q   <= credits_q + CREDIT_W'(cdb_credit_i) - CREDIT_W'(send);
            out_valid_q <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (res_i.valid) begin
            tag_mem[wr_ptr_q] <= res_i.tag;
            val_mem[wr_ptr_q] <= res_i.value;
        end
        if (send) begin
            out_tag_q   <= tag_mem[rd_ptr_q];
            out_value_q <= val_mem[rd_ptr_q];
        end
    end

    assign result_o = '{
        valid: out_valid_q,
        tag:   out_tag_q,
        value: out_value_q
    };

endmodule

`default_nettype wire

// ==== src/cmp_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_unit (
    input  logic            clk,
    input  logic            rst_n_i,
    input  cmp_pkg::issue_t issue_i,
    output cmp_pkg::cdb_t   res_o
);
    import cmp_pkg::*;

    logic             cmp_bit;
    logic             res_valid_q;
    logic [TAG_W-1:0] res_tag_q;
    logic [XLEN-1:0]  res_value_q;

    always_comb begin
        case (issue_i.op)
            CMP_EQ:  cmp_bit = (issue_i.a == issue_i.b);
            CMP_NE:  cmp_bit = (issue_i.a != issue_i.b);
            CMP_LT:  cmp_bit = ($signed(issue_i.a) < $signed(issue_i.b));
            CMP_GE:  cmp_bit = ($signed(issue_i.a) >= $signed(issue_i.b));
            CMP_LTU: cmp_bit = (issue_i.a < issue_i.b);
            CMP_GEU: cmp_bit = (issue_i.a >= issue_i.b);
            default: cmp_bit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= issue_i.valid;
        end
    end

    // result is a zero extended single bit in slt style
    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            res_tag_q   <= issue_i.dest_tag;
            res_value_q <= {{(XLEN - 1){1'b0}}, cmp_bit};
        end
    end

    assign res_o = '{
        valid: res_valid_q,
        tag:   res_tag_q,
        value: res_value_q
    };

endmodule

`default_nettype wire

// ==== src/cmp_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_station (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  cmp_pkg::dispatch_t cap_i,
    input  cmp_pkg::cdb_t      snoop_i,
    input  logic               space_i,
    output cmp_pkg::issue_t    issue_o,
    output logic               credit_o
);
    import cmp_pkg::*;

    entry_state_e             state_q [STATION_DEPTH];
    logic [STATION_IDX_W-1:0] age_q   [STATION_DEPTH];
    operand_t                 src1_q  [STATION_DEPTH];
    operand_t                 src2_q  [STATION_DEPTH];
    cmp_op_e                  op_q    [STATION_DEPTH];
    logic [TAG_W-1:0]         dest_q  [STATION_DEPTH];

    operand_t                 nxt_src1 [STATION_DEPTH];
    operand_t                 nxt_src2 [STATION_DEPTH];

    logic                     have_free;
    logic [STATION_IDX_W-1:0] alloc_idx;
    logic                     alloc;
    logic                     have_ready;
    logic [STATION_IDX_W-1:0] sel_idx;
    logic                     issue_fire;
    logic [STATION_IDX_W:0]   occupied;
    logic [STATION_IDX_W:0]   remaining;

    // lowest free slot, occupancy, and oldest ready entry
    // age counts the older entries still held, so zero is the oldest
    always_comb begin
        have_free  = 1'b0;
        alloc_idx  = '0;
        have_ready = 1'b0;
        sel_idx    = '0;
        occupied   = '0;
        for (int i = 0; i < STATION_DEPTH; i++) begin
            if (state_q[i] == ENTRY_FREE) begin
                if (!have_free) begin
                    have_free = 1'b1;
                    alloc_idx = STATION_IDX_W'(i);
                end
            end else begin
                occupied = occupied + 1'b1;
            end
            if (state_q[i] == ENTRY_READY) begin
                if (!have_ready || (age_q[i] < age_q[sel_idx])) begin
                    have_ready = 1'b1;
                    sel_idx    = STATION_IDX_W'(i);
                end
            end
        end
    end

    assign alloc      = cap_i.valid && have_free && !flush_i;
    assign issue_fire = have_ready && space_i && !flush_i;
    assign remaining  = occupied - {{STATION_IDX_W{1'b0}}, issue_fire};

    // operands after this cycle's snoop, new capture in its slot
    always_comb begin
        for (int i = 0; i < STATION_DEPTH; i++) begin
            if (alloc && (alloc_idx == STATION_IDX_W'(i))) begin
                nxt_src1[i] = wake_operand(cap_i.src1, snoop_i);
                nxt_src2[i] = wake_operand(cap_i.src2, snoop_i);
            end else begin
                nxt_src1[i] = wake_operand(src1_q[i], snoop_i);
                nxt_src2[i] = wake_operand(src2_q[i], snoop_i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STATION_DEPTH; i++) begin
                state_q[i] <= ENTRY_FREE;
                age_q[i]   <= '0;
            end
        end else if (flush_i) begin
            // entries vanish, no credits go back
            for (int i = 0; i < STATION_DEPTH; i++) begin
                state_q[i] <= ENTRY_FREE;
                age_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < STATION_DEPTH; i++) begin
                if (issue_fire && (sel_idx == STATION_IDX_W'(i))) begin
                    state_q[i] <= ENTRY_FREE;
                end else if (alloc && (alloc_idx == STATION_IDX_W'(i))) begin
                    state_q[i] <= (nxt_src1[i].ready && nxt_src2[i].ready) ?
                                  ENTRY_READY : ENTRY_WAIT;
                    age_q[i]   <= remaining[STATION_IDX_W-1:0];
                end else if (state_q[i] != ENTRY_FREE) begin
                    state_q[i] <= (nxt_src1[i].ready && nxt_src2[i].ready) ?
                                  ENTRY_READY : ENTRY_WAIT;
                    // younger entries move up when an older one leaves
                    if (issue_fire && (age_q[i] > age_q[sel_idx])) begin
                        age_q[i] <= age_q[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < STATION_DEPTH; i++) begin
            src1_q[i] <= nxt_src1[i];
            src2_q[i] <= nxt_src2[i];
            if (alloc && (alloc_idx == STATION_IDX_W'(i))) begin
                op_q[i]   <= cap_i.op;
                dest_q[i] <= cap_i.dest_tag;
            end
        end
    end

    assign issue_o = '{
        valid:    issue_fire,
        op:       op_q[sel_idx],
        a:        src1_q[sel_idx].value,
        b:        src2_q[sel_idx].value,
        dest_tag: dest_q[sel_idx]
    };

    // one dispatch credit per issued entry
    assign credit_o = issue_fire;

endmodule

`default_nettype wire

// ==== src/cmp_dispatch_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmp_dispatch_capture (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  cmp_pkg::dispatch_t dispatch_i,
    input  cmp_pkg::cdb_t      snoop_i,
    output cmp_pkg::dispatch_t cap_o
);
    import cmp_pkg::*;

    logic             cap_valid_q;
    cmp_op_e          cap_op_q;
    operand_t         cap_src1_q;
    operand_t         cap_src2_q;
    logic [TAG_W-1:0] cap_dest_q;

    // valid follows the dispatch every cycle and flush drops it
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cap_valid_q <= 1'b0;
        end else if (flush_i) begin
            cap_valid_q <= 1'b0;
        end else begin
            cap_valid_q <= dispatch_i.valid;
        end
    end

    // same-cycle broadcast must not slip past the register
    always_ff @(posedge clk) begin
        if (dispatch_i.valid) begin
            cap_op_q   <= dispatch_i.op;
            cap_src1_q <= wake_operand(dispatch_i.src1, snoop_i);
            cap_src2_q <= wake_operand(dispatch_i.src2, snoop_i);
            cap_dest_q <= dispatch_i.dest_tag;
        end
    end

    assign cap_o = '{
        valid:    cap_valid_q,
        op:       cap_op_q,
        src1:     cap_src1_q,
        src2:     cap_src2_q,
        dest_tag: cap_dest_q
    };

endmodule

`default_nettype wire

// ==== src/cmp_pkg.sv ====
`default_nettype none

package cmp_pkg;

    // datapath and tag widths
    localparam int XLEN = 32;
    localparam int TAG_W = 4;

    // buffer sizes and starting credits
    localparam int STATION_DEPTH = 4;
    localparam int RESULT_DEPTH = 4;
    localparam int CDB_CREDITS = 2;

    // derived widths
    localparam int STATION_IDX_W = $clog2(STATION_DEPTH);
    localparam int RESULT_PTR_W = $clog2(RESULT_DEPTH);
    localparam int RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);
    localparam int CREDIT_W = $clog2(CDB_CREDITS + 1);

    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_op_e;

    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_WAIT,
        ENTRY_READY
    } entry_state_e;

    // value only meaningful once ready is set
    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic             valid;
        cmp_op_e          op;
        operand_t         src1;
        operand_t         src2;
        logic [TAG_W-1:0] dest_tag;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        cmp_op_e          op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [TAG_W-1:0] dest_tag;
    } issue_t;

    // grab a broadcast value for an operand still waiting on that tag
    function automatic operand_t wake_operand(operand_t opnd, cdb_t snoop);
        operand_t woken;
        woken = opnd;
        if (!opnd.ready && snoop.valid && (snoop.tag == opnd.tag)) begin
            woken.ready = 1'b1;
            woken.value = snoop.value;
        end
        return woken;
    endfunction

endpackage

`default_nettype wire
